// File: verilog/vote_cfg.svh
`ifndef VOTE_CFG_SVH
`define VOTE_CFG_SVH

// compute lanes per input vector
`define VOTE_LANES 14

// weight words in the bank
`define VOTE_DEPTH 16
// address width of the bank, covers VOTE_DEPTH
`define VOTE_ADDR_W 4

// signed accumulator width
`define VOTE_SCORE_W 30

// one vector's vote sum, -14 .. +14 signed
`define VOTE_SUM_W 5

`endif

// File: verilog/vote_pkg.sv
`include "vote_cfg.svh"

package vote_pkg;

    // one lane's result for one vector
    // store marks a lane that took part, agree is the xnor
    typedef struct packed {
        logic store;
        logic agree;
    } lane_vote_t;

    // all lanes side by side, lane 0 in the low bits
    typedef lane_vote_t [`VOTE_LANES-1:0] lane_bus_t;

    // +1, 0 or -1
    typedef logic signed [1:0] vote_t;

    // sum of one vector's votes
    typedef logic signed [`VOTE_SUM_W-1:0] vote_sum_t;

    // running neuron score
    typedef logic signed [`VOTE_SCORE_W-1:0] score_t;

    localparam vote_t VOTE_POS  = 2'sd1;
    localparam vote_t VOTE_ZERO = 2'sd0;
    localparam vote_t VOTE_NEG  = -2'sd1;

endpackage

// File: verilog/weight_bank.sv
`default_nettype none

`include "vote_cfg.svh"

module weight_bank (
    input  logic                    clk,
    input  logic                    rst,
    // external write port, only used while no vector is in flight
    input  logic                    wr,
    input  logic [`VOTE_ADDR_W-1:0] wr_addr,
    input  logic [`VOTE_LANES-1:0]  wr_data,
    // one pulse per accepted input vector
    input  logic                    step,
    // start of a new neuron
    input  logic                    restart,
    output logic [`VOTE_LANES-1:0]  cur_weight
);

    // last word before the pointer wraps
    localparam logic [`VOTE_ADDR_W-1:0] LAST_ADDR = `VOTE_ADDR_W'(`VOTE_DEPTH - 1);

    // weight storage
    logic [`VOTE_LANES-1:0]  mem [`VOTE_DEPTH];

    // word used by the next vector
    logic [`VOTE_ADDR_W-1:0] rd_ptr;

    // write lands on the edge of the strobe
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // pointer steps once per vector
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            rd_ptr <= '0;
        end else if (step) begin
            // wrap back to word 0
            if (rd_ptr == LAST_ADDR) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // read is combinational so the lane stage
    // samples the word on the same edge as the vector
    assign cur_weight = mem[rd_ptr];

endmodule

`default_nettype wire

// File: verilog/xnor_lanes.sv
`default_nettype none

`include "vote_cfg.svh"

module xnor_lanes (
    input  logic                   clk,
    input  logic                   rst,
    // vector strobe, one cycle per vector
    input  logic                   act_valid,
    input  logic [`VOTE_LANES-1:0] act,
    // per-lane mask, 0 keeps a lane out of the vote
    input  logic [`VOTE_LANES-1:0] lane_en,
    // weight word at the current pointer
    input  logic [`VOTE_LANES-1:0] weight,
    output vote_pkg::lane_bus_t    lanes,
    output logic                   vec_valid
);

    // binary multiply is an xnor
    logic [`VOTE_LANES-1:0] agree_c;

    // lane takes part only on a valid vector
    logic [`VOTE_LANES-1:0] store_c;

    assign agree_c = ~(act ^ weight);
    assign store_c = lane_en & {`VOTE_LANES{act_valid}};

    always_ff @(posedge clk) begin
        // agreement bits are payload
        for (int i = 0; i < `VOTE_LANES; i++) begin
            lanes[i].agree <= agree_c[i];
        end

        if (rst) begin
            vec_valid <= 1'b0;
            for (int i = 0; i < `VOTE_LANES; i++) begin
                lanes[i].store <= 1'b0;
            end
        end else begin
            // strobe follows the lanes down the pipe
            vec_valid <= act_valid;
            for (int i = 0; i < `VOTE_LANES; i++) begin
                lanes[i].store <= store_c[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/selector.sv
`default_nettype none

module selector (
    input  logic                 clk,
    input  logic                 rst,
    // store and agree bits of one lane
    input  vote_pkg::lane_vote_t lane,
    // registered vote
    output vote_pkg::vote_t      sel
);

    import vote_pkg::*;

    // vote encoding
    //   no store         -> 0
    //   store and agree  -> +1
    //   store, disagree  -> -1
    always_ff @(posedge clk) begin
        if (rst) begin
            sel <= VOTE_ZERO;
        end else if (!lane.store) begin
            // masked lane or idle cycle
            sel <= VOTE_ZERO;
        end else if (lane.agree) begin
            sel <= VOTE_POS;
        end else begin
            sel <= VOTE_NEG;
        end
    end

endmodule

`default_nettype wire

// File: verilog/counter.sv
`default_nettype none

`include "vote_cfg.svh"

module counter (
    input  logic                clk,
    input  logic                rst,
    // new neuron, zeroes sum and score
    input  logic                clear,
    // lane results from the xnor stage
    input  vote_pkg::lane_bus_t lanes,
    input  logic                vec_valid,
    // accumulated score and its sign
    output vote_pkg::score_t    score,
    output logic                sign_bit
);

    import vote_pkg::*;

    // one registered vote per lane
    vote_t     votes [`VOTE_LANES];

    // adder tree output, before the register
    vote_sum_t vote_sum_c;

    // registered sum of one vector
    vote_sum_t vote_sum;

    // strobe delayed to line up with vote_sum
    logic      valid_d1;
    logic      valid_d2;

    // one selector per lane
    for (genvar k = 0; k < `VOTE_LANES; k++) begin : g_lane
        selector u_selector (
            .clk  (clk),
            .rst  (rst),
            .lane (lanes[k]),
            .sel  (votes[k])
        );
    end

    // signed add of all lane votes
    // each vote is sign extended to the sum width
    always_comb begin
        vote_sum_c = '0;
        for (int i = 0; i < `VOTE_LANES; i++) begin
            vote_sum_c = vote_sum_c + vote_sum_t'(votes[i]);
        end
    end

    // vec_valid at E, votes at E+1, sum at E+2
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_d1 <= 1'b0;
            valid_d2 <= 1'b0;
        end else begin
            valid_d1 <= vec_valid;
            valid_d2 <= valid_d1;
        end
    end

    // sum and accumulate run as separate stages
    // so back-to-back vectors each get counted
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            vote_sum <= '0;
            score    <= '0;
        end else begin
            vote_sum <= vote_sum_c;
            // score picks up the vector at E+3
            if (valid_d2) begin
                score <= score + score_t'(vote_sum);
            end
        end
    end

    // neuron fires on a non-negative score
    // sign bit of the accumulator
    assign sign_bit = score[`VOTE_SCORE_W-1];

endmodule

`default_nettype wire

// File: verilog/bnn_neuron_top.sv
`default_nettype none

`include "vote_cfg.svh"

module bnn_neuron_top (
    input  logic                    clk,
    input  logic                    rst,
    // start of a new neuron
    input  logic                    clear,
    // weight load port
    input  logic                    wt_wr,
    input  logic [`VOTE_ADDR_W-1:0] wt_addr,
    input  logic [`VOTE_LANES-1:0]  wt_data,
    // input vectors
    input  logic                    act_valid,
    input  logic [`VOTE_LANES-1:0]  act,
    input  logic [`VOTE_LANES-1:0]  lane_en,
    // neuron result
    output vote_pkg::score_t        score,
    output logic                    sign_bit
);

    import vote_pkg::*;

    // weight word for the vector on the bus now
    logic [`VOTE_LANES-1:0] cur_weight;

    // xnor stage to counter
    lane_bus_t              lanes;
    logic                   vec_valid;

    // weight storage
    // clear restarts at word 0, each vector steps the pointer
    weight_bank u_weight_bank (
        .clk        (clk),
        .rst        (rst),
        .wr         (wt_wr),
        .wr_addr    (wt_addr),
        .wr_data    (wt_data),
        .step       (act_valid),
        .restart    (clear),
        .cur_weight (cur_weight)
    );

    // per-lane agreement and store strobes
    xnor_lanes u_xnor_lanes (
        .clk       (clk),
        .rst       (rst),
        .act_valid (act_valid),
        .act       (act),
        .lane_en   (lane_en),
        .weight    (cur_weight),
        .lanes     (lanes),
        .vec_valid (vec_valid)
    );

    // votes, vector sum, score
    // four edges from the sampling edge to the new score
    counter u_counter (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .lanes     (lanes),
        .vec_valid (vec_valid),
        .score     (score),
        .sign_bit  (sign_bit)
    );

endmodule

`default_nettype wire

// File: bench/bnn_neuron_props.sv
`include "vote_cfg.svh"

module bnn_neuron_props (
    input logic             clk,
    input logic             rst,
    input logic             clear,
    input vote_pkg::score_t score,
    input logic             sign_bit
);

    timeunit 1ns;
    timeprecision 1ps;

    import vote_pkg::*;

    // one vector moves the score by at most one vote per lane
    localparam score_t MAX_STEP = score_t'(`VOTE_LANES);

    // sign output is the accumulator msb
    a_sign_is_msb: assert property (@(posedge clk)
        sign_bit == score[`VOTE_SCORE_W-1])
    else $error("sign_bit differs from the score msb");

    // reset and clear both zero the score on the next edge
    a_zero_after_clear: assert property (@(posedge clk)
        (rst || clear) |=> (score == '0))
    else $error("score not zero after reset or clear");

    // bounded change per cycle, outside reset and clear
    a_bounded_step: assert property (@(posedge clk) disable iff (rst)
        (!$past(rst) && !$past(clear)) |->
            ((score - $past(score) <= MAX_STEP) && ($past(score) - score <= MAX_STEP)))
    else $error("score moved by more than one vector's worth in a cycle");

endmodule

bind bnn_neuron_top bnn_neuron_props u_props (
    .clk      (clk),
    .rst      (rst),
    .clear    (clear),
    .score    (score),
    .sign_bit (sign_bit)
);

// File: bench/tb_bnn_neuron.sv
`include "vote_cfg.svh"

module tb_bnn_neuron;

    timeunit 1ns;
    timeprecision 1ps;

    import vote_pkg::*;

    // phase lengths in cycles
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 10;
    localparam int DRAIN_CYCLES = 5;
    localparam int CLEAR_GAP    = 2;
    localparam int RISE_VECS    = 5;
    localparam int FALL_VECS    = 10;
    localparam int WRAP_VECS    = 40;
    localparam int MIXED_CYCLES = 24;
    localparam int MASKED_VECS  = 6;

    // every cycle the stimulus drives, start to report
    localparam int STIM_CYCLES = RESET_CYCLES + IDLE_CYCLES + 2 * `VOTE_DEPTH
        + RISE_VECS + FALL_VECS + WRAP_VECS + MIXED_CYCLES + MASKED_VECS
        + 5 * DRAIN_CYCLES + 2 * (1 + CLEAR_GAP);
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

    localparam logic [`VOTE_LANES-1:0] ALL_LANES = {`VOTE_LANES{1'b1}};

    logic                    clk;
    logic                    rst;
    logic                    clear;
    logic                    wt_wr;
    logic [`VOTE_ADDR_W-1:0] wt_addr;
    logic [`VOTE_LANES-1:0]  wt_data;
    logic                    act_valid;
    logic [`VOTE_LANES-1:0]  act;
    logic [`VOTE_LANES-1:0]  lane_en;
    score_t                  score;
    logic                    sign_bit;

    // reference state
    logic [`VOTE_LANES-1:0]  wt_mirror [`VOTE_DEPTH];
    logic [`VOTE_ADDR_W-1:0] exp_ptr;
    int                      exp_score;
    // three-deep delay line, fourth edge adds into the score
    int                      sum_pipe [$];
    logic                    seen_reset = 1'b0;

    integer seed = 32'hc58ce84b;
    int     check_count = 0;
    int     error_count = 0;
    int     cycle_count = 0;

    bnn_neuron_top uut (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .wt_wr     (wt_wr),
        .wt_addr   (wt_addr),
        .wt_data   (wt_data),
        .act_valid (act_valid),
        .act       (act),
        .lane_en   (lane_en),
        .score     (score),
        .sign_bit  (sign_bit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected vote sum of one vector
    // enabled lane votes +1 on a match, -1 otherwise
    function automatic int vector_sum(input logic [`VOTE_LANES-1:0] a,
                                      input logic [`VOTE_LANES-1:0] en,
                                      input logic [`VOTE_LANES-1:0] w);
        int total;
        total = 0;
        for (int i = 0; i < `VOTE_LANES; i++) begin
            if (en[i]) begin
                total += (a[i] == w[i]) ? 1 : -1;
            end
        end
        return total;
    endfunction

    function automatic logic [`VOTE_LANES-1:0] rand_lanes();
        logic [31:0] rnd;
        rnd = $random(seed);
        return rnd[`VOTE_LANES-1:0];
    endfunction

    task automatic check_value(input string what, input logic signed [31:0] got,
                               input logic signed [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t ns: %s mismatch, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // strobes low, payload kept
    task automatic quiet_inputs();
        clear     = 1'b0;
        wt_wr     = 1'b0;
        act_valid = 1'b0;
    endtask

    // each driver sets inputs at a falling edge and waits for the next one
    task automatic step_idle(input int n);
        repeat (n) begin
            quiet_inputs();
            @(negedge clk);
        end
    endtask

    task automatic send_vector(input logic [`VOTE_LANES-1:0] a,
                               input logic [`VOTE_LANES-1:0] en);
        quiet_inputs();
        act_valid = 1'b1;
        act       = a;
        lane_en   = en;
        @(negedge clk);
    endtask

    task automatic pulse_clear();
        quiet_inputs();
        clear = 1'b1;
        @(negedge clk);
    endtask

    // fill every word with random weights
    task automatic load_weights();
        for (int a = 0; a < `VOTE_DEPTH; a++) begin
            quiet_inputs();
            wt_wr   = 1'b1;
            wt_addr = `VOTE_ADDR_W'(a);
            wt_data = rand_lanes();
            @(negedge clk);
        end
    endtask

    // reference model, follows the inputs on each rising edge
    always @(posedge clk) begin
        if (rst) begin
            exp_score  = 0;
            exp_ptr    = '0;
            seen_reset = 1'b1;
            sum_pipe.delete();
            repeat (3) sum_pipe.push_back(0);
        end else if (seen_reset) begin
            exp_score = exp_score + sum_pipe.pop_front();
            if (clear) begin
                exp_score = 0;
                exp_ptr   = '0;
            end
            if (act_valid) begin
                sum_pipe.push_back(vector_sum(act, lane_en, wt_mirror[exp_ptr]));
                // pointer wraps after the last word
                if (exp_ptr == `VOTE_ADDR_W'(`VOTE_DEPTH - 1)) begin
                    exp_ptr = '0;
                end else begin
                    exp_ptr = exp_ptr + 1'b1;
                end
            end else begin
                sum_pipe.push_back(0);
            end
        end
        // write lands after this edge's read
        if (wt_wr) begin
            wt_mirror[wt_addr] = wt_data;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (seen_reset) begin
            check_value("score", 32'(score), exp_score);
            check_value("sign_bit", 32'(sign_bit), (exp_score < 0) ? 1 : 0);
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [`VOTE_LANES-1:0] pick;
        int                     held_score;
        rst       = 1'b1;
        clear     = 1'b0;
        wt_wr     = 1'b0;
        wt_addr   = '0;
        wt_data   = '0;
        act_valid = 1'b0;
        act       = '0;
        lane_en   = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // idle after reset, nothing moves
        step_idle(IDLE_CYCLES);
        check_value("score at idle", 32'(score), 0);

        load_weights();

        // act equal to the weights, +14 per vector
        for (int v = 0; v < RISE_VECS; v++) begin
            send_vector(wt_mirror[exp_ptr], ALL_LANES);
        end
        step_idle(DRAIN_CYCLES);
        check_value("score after matching vectors", 32'(score), RISE_VECS * `VOTE_LANES);

        // inverted act, -14 per vector, ends negative
        for (int v = 0; v < FALL_VECS; v++) begin
            send_vector(~wt_mirror[exp_ptr], ALL_LANES);
        end
        step_idle(DRAIN_CYCLES);
        check_value("score after inverted vectors", 32'(score),
                    (RISE_VECS - FALL_VECS) * `VOTE_LANES);
        check_value("sign_bit after inverted vectors", 32'(sign_bit), 1);

        // new neuron, then back-to-back random vectors past the last word
        pulse_clear();
        step_idle(CLEAR_GAP);
        check_value("score after clear", 32'(score), 0);
        for (int v = 0; v < WRAP_VECS; v++) begin
            send_vector(rand_lanes(), rand_lanes());
        end
        step_idle(DRAIN_CYCLES);

        // fresh weights for a second neuron, vectors with random gaps
        pulse_clear();
        step_idle(CLEAR_GAP);
        check_value("score after second clear", 32'(score), 0);
        load_weights();
        for (int c = 0; c < MIXED_CYCLES; c++) begin
            pick = rand_lanes();
            // about three cycles in four carry a vector
            if (pick[1:0] != 2'b00) begin
                send_vector(rand_lanes(), rand_lanes());
            end else begin
                step_idle(1);
            end
        end
        step_idle(DRAIN_CYCLES);

        // all lanes masked, score holds
        held_score = exp_score;
        for (int v = 0; v < MASKED_VECS; v++) begin
            send_vector(rand_lanes(), '0);
        end
        step_idle(DRAIN_CYCLES);
        check_value("score after masked vectors", 32'(score), held_score);

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
verilog/vote_pkg.sv
verilog/weight_bank.sv
verilog/xnor_lanes.sv
verilog/selector.sv
verilog/counter.sv
verilog/bnn_neuron_top.sv
bench/bnn_neuron_props.sv
bench/tb_bnn_neuron.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bnn neuron testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

# compile rtl, bound assertions and testbench into one binary
verilator --binary --timing --assert -j 0 \
    --top-module tb_bnn_neuron \
    --Mdir "$build_dir" \
    -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# run, keep the whole transcript
"./$build_dir/Vtb_bnn_neuron" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

# pass only on the exact pass line
if grep -q "^TEST OK$" "$log_file"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $log_file"
    exit 1
fi
